// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_serial_bus_slaves
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
VERILATOR_FLAGS ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "Everything OK"

clean:
	rm -rf $(BUILD_DIR)

// File: source/bank_pkg.sv
/* Storage bank types */

`include "serial_bus_consts.svh"

package bank_pkg;

	// Selects one of the banks.
	typedef logic [$clog2(`SB_NUM_BANKS)-1:0] bank_index_t;

	// One stored byte.
	typedef logic [`SB_DATA_BITS-1:0] word_t;

	// Location inside one bank.
	typedef logic [$clog2(`SB_BANK_WORDS)-1:0] word_addr_t;

endpackage

// File: source/bank_router.sv
/* Bank selection router */

`timescale 1ns/10ps

`include "serial_bus_consts.svh"

module bank_router (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      master_valid,
	input  bank_pkg::bank_index_t     bank_sel,
	input  logic                      read_en,
	input  logic                      write_en,
	input  logic [`SB_NUM_BANKS-1:0]  bank_ready,
	input  logic [`SB_NUM_BANKS-1:0]  txn_done,
	output logic                      slave_ready,
	output logic [`SB_NUM_BANKS-1:0]  bank_valid,
	output logic [`SB_NUM_BANKS-1:0]  bank_read_en,
	output logic [`SB_NUM_BANKS-1:0]  bank_write_en
);

	bank_pkg::bank_index_t owner;
	bank_pkg::bank_index_t sel;
	logic locked;
	logic active;
	logic handshake;

	// Lock drops as soon as the owner reports its last beat.
	assign active = locked && !txn_done[owner];
	assign sel = active ? owner : bank_sel;
	assign slave_ready = bank_ready[sel];
	assign handshake = master_valid && slave_ready;

	always_comb
	begin
		for (int i = 0; i < `SB_NUM_BANKS; i++)
		begin
			bank_valid[i]    = master_valid && (sel == bank_pkg::bank_index_t'(i));
			bank_read_en[i]  = read_en && (sel == bank_pkg::bank_index_t'(i));
			bank_write_en[i] = write_en && (sel == bank_pkg::bank_index_t'(i));
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			owner  <= '0;
			locked <= 1'b0;
		end
		else if (handshake && !active)
		begin
			owner  <= bank_sel; // First handshake picks the bank.
			locked <= 1'b1;
		end
		else if (locked && txn_done[owner])
			locked <= 1'b0;
	end

endmodule

// File: source/bus_pkg.sv
/* Serial bus protocol types */

`include "serial_bus_consts.svh"

package bus_pkg;

	// Phases of the two port machines.
	typedef enum logic [2:0]
	{
		PH_IDLE       = 3'd0, // Waiting for a handshake.
		PH_ADDR_SHIFT = 3'd1, // Address bits coming in.
		PH_WAIT_BEAT  = 3'd2, // Burst waiting for next handshake.
		PH_DATA_SHIFT = 3'd3, // Write byte coming in.
		PH_BEAT_GAP   = 3'd4  // Counting out a burst beat.
	} port_phase_t;

	// Start address of a transaction.
	typedef logic [`SB_ADDR_BITS-1:0] bus_addr_t;

	// Bit 0 enables the burst, upper bits count the extra beats.
	typedef logic [`SB_BURST_BITS-1:0] burst_field_t;

endpackage

// File: source/read_serializer.sv
/* Read data serializer */

`timescale 1ns/10ps

`include "serial_bus_consts.svh"

module read_serializer (
	input  logic                     clk,
	input  logic                     reset,
	input  logic [`SB_NUM_BANKS-1:0] read_valid,
	input  bank_pkg::word_t          read_byte [`SB_NUM_BANKS],
	output logic                     tx_valid,
	output logic                     tx_data
);

	localparam int CNT_W = $clog2(`SB_DATA_BITS + 1);

	bank_pkg::word_t pick;
	bank_pkg::word_t shift_q;
	logic [CNT_W-1:0] bits_left;
	logic load;

	// At most one bank answers at a time.
	always_comb
	begin
		pick = '0;
		for (int i = 0; i < `SB_NUM_BANKS; i++)
		begin
			if (read_valid[i])
				pick = read_byte[i];
		end
	end

	assign load = |read_valid;
	assign tx_valid = (bits_left != '0);
	assign tx_data = shift_q[0]; // LSB first.

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			bits_left <= '0;
		else if (load)
			bits_left <= CNT_W'(`SB_DATA_BITS);
		else if (bits_left != '0)
			bits_left <= bits_left - 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (load)
			shift_q <= pick;
		else if (bits_left != '0)
			shift_q <= shift_q >> 1;
	end

endmodule

// File: source/serial_bus_consts.svh
/* Serial bus slave constants */

`ifndef SERIAL_BUS_CONSTS_SVH
`define SERIAL_BUS_CONSTS_SVH

// Serial address, shifted in LSB first.
`define SB_ADDR_BITS 12

// Data byte carried by each beat.
`define SB_DATA_BITS 8

// Banks behind the shared port.
`define SB_NUM_BANKS 4

// Bytes held by one bank, low address bits only.
`define SB_BANK_WORDS 64

// Burst enable plus extra beat count.
`define SB_BURST_BITS 13

`endif

// File: source/serial_bus_slaves.sv
/* Serial bus slave subsystem */

`timescale 1ns/10ps

`include "serial_bus_consts.svh"

module serial_bus_slaves (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  master_valid,
	input  bank_pkg::bank_index_t bank_sel,
	input  logic                  read_en,
	input  logic                  write_en,
	input  bus_pkg::burst_field_t burst,
	input  logic                  rx_address,
	input  logic                  rx_data,
	output logic                  slave_ready,
	output logic                  tx_valid,
	output logic                  tx_data
);

	logic [`SB_NUM_BANKS-1:0] bank_valid;
	logic [`SB_NUM_BANKS-1:0] bank_read_en;
	logic [`SB_NUM_BANKS-1:0] bank_write_en;
	logic [`SB_NUM_BANKS-1:0] bank_ready;
	logic [`SB_NUM_BANKS-1:0] txn_done;
	logic [`SB_NUM_BANKS-1:0] read_valid;
	bank_pkg::word_t read_byte [`SB_NUM_BANKS];

	bank_router u_router (
		.clk           (clk),
		.reset         (reset),
		.master_valid  (master_valid),
		.bank_sel      (bank_sel),
		.read_en       (read_en),
		.write_en      (write_en),
		.bank_ready    (bank_ready),
		.txn_done      (txn_done),
		.slave_ready   (slave_ready),
		.bank_valid    (bank_valid),
		.bank_read_en  (bank_read_en),
		.bank_write_en (bank_write_en)
	);

	// Serial address and data lines are shared by all banks.
	for (genvar i = 0; i < `SB_NUM_BANKS; i++)
	begin : g_bank
		slave_bank u_bank (
			.clk          (clk),
			.reset        (reset),
			.master_valid (bank_valid[i]),
			.read_en      (bank_read_en[i]),
			.write_en     (bank_write_en[i]),
			.burst        (burst),
			.rx_address   (rx_address),
			.rx_data      (rx_data),
			.slave_ready  (bank_ready[i]),
			.txn_done     (txn_done[i]),
			.read_valid   (read_valid[i]),
			.read_byte    (read_byte[i])
		);
	end

	read_serializer u_serializer (
		.clk        (clk),
		.reset      (reset),
		.read_valid (read_valid),
		.read_byte  (read_byte),
		.tx_valid   (tx_valid),
		.tx_data    (tx_data)
	);

endmodule

// File: source/serial_slave_port.sv
/* Serial slave input port */

`timescale 1ns/10ps

`include "serial_bus_consts.svh"

module serial_slave_port (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  rx_address,
	input  logic                  rx_data,
	input  logic                  master_valid,
	input  logic                  read_en,
	input  logic                  write_en,
	input  bus_pkg::burst_field_t burst,
	output logic                  slave_ready,
	output logic                  rx_done,
	output logic                  txn_done,
	output bus_pkg::bus_addr_t    address,
	output bank_pkg::word_t       data,
	output logic                  read_strobe,
	output logic                  write_strobe
);

	localparam int ACNT_W = $clog2(`SB_ADDR_BITS + 1);
	localparam int DCNT_W = $clog2(`SB_DATA_BITS + 1);
	localparam int DIDX_W = $clog2(`SB_DATA_BITS);
	localparam logic [ACNT_W-1:0] ADDR_END = ACNT_W'(`SB_ADDR_BITS);
	localparam logic [ACNT_W-1:0] BEAT_END = ACNT_W'(`SB_DATA_BITS);
	localparam logic [DCNT_W-1:0] DATA_END = DCNT_W'(`SB_DATA_BITS);

	bus_pkg::port_phase_t addr_phase;
	bus_pkg::port_phase_t data_phase;
	logic [ACNT_W-1:0] addr_count;
	logic [DCNT_W-1:0] data_count;
	logic [`SB_BURST_BITS-2:0] beat_count;
	bus_pkg::burst_field_t burst_q;
	logic rd_q;
	logic wr_q;
	logic handshake;
	logic addr_idle;
	logic beat_end;
	logic more_beats;
	logic data_start;

	assign addr_idle = (addr_phase == bus_pkg::PH_IDLE) || (addr_phase == bus_pkg::PH_WAIT_BEAT);
	assign slave_ready = addr_idle && (data_phase == bus_pkg::PH_IDLE);
	assign handshake = master_valid && slave_ready;

	// First beat ends after 12 bits, later beats after 8.
	assign beat_end = (addr_phase == bus_pkg::PH_ADDR_SHIFT) ? (addr_count == ADDR_END)
		: (addr_count == BEAT_END);
	assign more_beats = burst_q[0] && (beat_count < burst_q[`SB_BURST_BITS-1:1]);

	// Only write beats shift a byte in.
	assign data_start = handshake
		&& (((addr_phase == bus_pkg::PH_IDLE) && write_en)
		|| ((addr_phase == bus_pkg::PH_WAIT_BEAT) && wr_q));

	assign read_strobe  = rx_done && rd_q;
	assign write_strobe = rx_done && wr_q;

	// Address and burst beat machine.
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			addr_phase <= bus_pkg::PH_IDLE;
			addr_count <= '0;
			beat_count <= '0;
			burst_q    <= '0;
			rd_q       <= 1'b0;
			wr_q       <= 1'b0;
			rx_done    <= 1'b0;
			txn_done   <= 1'b0;
		end
		else
		begin
			rx_done  <= 1'b0;
			txn_done <= 1'b0;
			case (addr_phase)
				bus_pkg::PH_IDLE:
				begin
					if (handshake)
					begin
						addr_phase <= bus_pkg::PH_ADDR_SHIFT;
						addr_count <= ACNT_W'(1); // Bit 0 taken on this edge.
						beat_count <= '0;
						burst_q    <= burst;
						rd_q       <= read_en;
						wr_q       <= write_en;
					end
				end
				bus_pkg::PH_WAIT_BEAT:
				begin
					if (handshake)
					begin
						addr_phase <= bus_pkg::PH_BEAT_GAP;
						addr_count <= ACNT_W'(1);
						beat_count <= beat_count + 1'b1;
					end
				end
				bus_pkg::PH_ADDR_SHIFT, bus_pkg::PH_BEAT_GAP:
				begin
					if (beat_end)
					begin
						rx_done    <= 1'b1;
						addr_count <= '0;
						if (more_beats)
							addr_phase <= bus_pkg::PH_WAIT_BEAT;
						else
						begin
							addr_phase <= bus_pkg::PH_IDLE;
							txn_done   <= 1'b1; // Last beat of the transaction.
						end
					end
					else
						addr_count <= addr_count + 1'b1;
				end
				default:
					addr_phase <= bus_pkg::PH_IDLE;
			endcase
		end
	end

	// Address shift register, bumped by one per burst beat.
	always_ff @(posedge clk)
	begin
		if ((addr_phase == bus_pkg::PH_IDLE) && handshake)
			address[0] <= rx_address;
		else if ((addr_phase == bus_pkg::PH_ADDR_SHIFT) && (addr_count < ADDR_END))
			address[addr_count] <= rx_address;
		else if ((addr_phase == bus_pkg::PH_WAIT_BEAT) && handshake)
			address <= address + 1'b1;
	end

	// Write data machine.
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			data_phase <= bus_pkg::PH_IDLE;
			data_count <= '0;
		end
		else
		begin
			case (data_phase)
				bus_pkg::PH_IDLE:
				begin
					if (data_start)
					begin
						data_phase <= bus_pkg::PH_DATA_SHIFT;
						data_count <= DCNT_W'(1);
					end
				end
				bus_pkg::PH_DATA_SHIFT:
				begin
					if (data_count < DATA_END)
						data_count <= data_count + 1'b1;
					else
					begin
						data_phase <= bus_pkg::PH_IDLE; // Byte complete.
						data_count <= '0;
					end
				end
				default:
					data_phase <= bus_pkg::PH_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (data_start)
			data[0] <= rx_data;
		else if ((data_phase == bus_pkg::PH_DATA_SHIFT) && (data_count < DATA_END))
			data[data_count[DIDX_W-1:0]] <= rx_data;
	end

endmodule

// File: source/slave_bank.sv
/* Storage bank with serial port */

`timescale 1ns/10ps

`include "serial_bus_consts.svh"

module slave_bank (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  master_valid,
	input  logic                  read_en,
	input  logic                  write_en,
	input  bus_pkg::burst_field_t burst,
	input  logic                  rx_address,
	input  logic                  rx_data,
	output logic                  slave_ready,
	output logic                  txn_done,
	output logic                  read_valid,
	output bank_pkg::word_t       read_byte
);

	bus_pkg::bus_addr_t address;
	bank_pkg::word_t data;
	bank_pkg::word_t mem [`SB_BANK_WORDS];
	bank_pkg::word_addr_t word_addr;
	logic read_strobe;
	logic write_strobe;

	// Upper address bits alias.
	assign word_addr = address[$bits(bank_pkg::word_addr_t)-1:0];

	serial_slave_port u_port (
		.clk          (clk),
		.reset        (reset),
		.rx_address   (rx_address),
		.rx_data      (rx_data),
		.master_valid (master_valid),
		.read_en      (read_en),
		.write_en     (write_en),
		.burst        (burst),
		.slave_ready  (slave_ready),
		.rx_done      (),
		.txn_done     (txn_done),
		.address      (address),
		.data         (data),
		.read_strobe  (read_strobe),
		.write_strobe (write_strobe)
	);

	always_ff @(posedge clk)
	begin
		if (write_strobe)
			mem[word_addr] <= data;
		if (read_strobe)
			read_byte <= mem[word_addr];
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			read_valid <= 1'b0;
		else
			read_valid <= read_strobe; // Byte ready one cycle after strobe.
	end

endmodule

// File: sources.f
+incdir+source
source/bus_pkg.sv
source/bank_pkg.sv
source/serial_slave_port.sv
source/bank_router.sv
source/slave_bank.sv
source/read_serializer.sv
source/serial_bus_slaves.sv
testbench/tb_serial_bus_slaves.sv

// File: testbench/bus_input.txt
# T <test name>, then one line per transaction:
# <W|R> <bank> <start address hex> <extra beats> <one byte hex per beat, expected for R>
T single_rw
W 0 005 0 a5
R 0 005 0 a5
T burst_rw
W 1 010 3 11 22 33 44
R 1 010 3 11 22 33 44
R 1 012 1 33 44
T bank_isolation
W 0 020 0 c0
W 1 020 0 c1
W 2 020 0 c2
W 3 020 0 c3
R 3 020 0 c3
R 2 020 0 c2
R 1 020 0 c1
R 0 020 0 c0
R 0 005 0 a5
T address_alias
W 2 007 0 5a
W 2 047 0 66
R 2 007 0 66
R 2 c87 0 66
W 3 03e 2 e1 e2 e3
R 3 000 0 e3
R 3 03e 2 e1 e2 e3
T burst_bank_lock
W 0 030 2 a0 a1 a2
W 1 030 2 b0 b1 b2
W 2 030 2 90 91 92
W 3 030 3 d0 d1 d2 d3
R 0 030 2 a0 a1 a2
R 1 030 2 b0 b1 b2
R 2 030 2 90 91 92
R 3 030 3 d0 d1 d2 d3
R 1 010 3 11 22 33 44
T writes_only
W 2 015 0 3c
W 3 016 1 4d 5e
T read_after_idle
R 2 015 0 3c
R 3 016 1 4d 5e

// File: testbench/tb_serial_bus_slaves.sv
/* Serial bus slave testbench */

`timescale 1ns/10ps

`include "serial_bus_consts.svh"

module tb_serial_bus_slaves;

	logic clk;
	logic reset;
	logic master_valid;
	bank_pkg::bank_index_t bank_sel;
	logic read_en;
	logic write_en;
	bus_pkg::burst_field_t burst;
	logic rx_address;
	logic rx_data;
	logic slave_ready;
	logic tx_valid;
	logic tx_data;

	logic [255:0] test_names [$];
	int txn_test [$];
	int txn_write [$];
	int txn_bank [$];
	int txn_addr [$];
	int txn_count [$];
	int txn_first [$]; // Index of the first byte in beat_bytes.
	int beat_bytes [$];
	int exp_frames [$];
	int rx_frames [$];
	string current_test;
	int errors;
	int checks;
	int test_errors;
	int cycle_count;
	int cycle_limit;
	int frame_bits;
	bank_pkg::word_t frame;
	logic [31:0] lcg_state;

	serial_bus_slaves u_serial_bus_slaves (
		.clk          (clk),
		.reset        (reset),
		.master_valid (master_valid),
		.bank_sel     (bank_sel),
		.read_en      (read_en),
		.write_en     (write_en),
		.burst        (burst),
		.rx_address   (rx_address),
		.rx_data      (rx_data),
		.slave_ready  (slave_ready),
		.tx_valid     (tx_valid),
		.tx_data      (tx_data)
	);

	always #10 clk = ~clk;

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic check_value(input string what, input int expected, input int actual);
		begin
			checks = checks + 1;
			if (expected != actual)
			begin
				errors = errors + 1;
				test_errors = test_errors + 1;
				$display("FAILED %0s %0s: expected %0h, actual %0h", current_test, what,
					expected, actual);
			end
		end
	endtask

	task automatic load_tests(output logic ok);
		int fd;
		int r;
		int bank;
		int addr;
		int count;
		int value;
		logic [7:0] tok;
		logic [255:0] name;
		logic [1023:0] skip_line;
		begin
			ok = 1'b0;
			fd = $fopen("testbench/bus_input.txt", "r");
			if (fd == 0)
				$display("Cannot open testbench/bus_input.txt.");
			else
			begin
				ok = 1'b1;
				while ($fscanf(fd, "%s", tok) == 1)
				begin
					if (tok == "#")
						r = $fgets(skip_line, fd);
					else if (tok == "T")
					begin
						r = $fscanf(fd, "%s", name);
						test_names.push_back(name);
					end
					else if ((tok == "W") || (tok == "R"))
					begin
						r = $fscanf(fd, "%d %h %d", bank, addr, count);
						if (r != 3)
						begin
							$display("Bad transaction line in testbench/bus_input.txt.");
							ok = 1'b0;
							count = 0;
						end
						txn_test.push_back(test_names.size() - 1);
						txn_write.push_back((tok == "W") ? 1 : 0);
						txn_bank.push_back(bank);
						txn_addr.push_back(addr);
						txn_count.push_back(count);
						txn_first.push_back(beat_bytes.size());
						for (int b = 0; b <= count; b++)
						begin
							r = $fscanf(fd, "%h", value);
							if (r != 1)
							begin
								$display("Missing beat byte in testbench/bus_input.txt.");
								ok = 1'b0;
							end
							beat_bytes.push_back(value);
						end
					end
					else
					begin
						$display("Unknown line type in testbench/bus_input.txt.");
						ok = 1'b0;
					end
				end
				$fclose(fd);
			end
		end
	endtask

	// Returns just after the edge that samples the handshake.
	task automatic wait_handshake();
		begin
			@(negedge clk);
			while (!slave_ready)
				@(negedge clk);
			@(posedge clk);
		end
	endtask

	task automatic drive_txn(input int k);
		bus_pkg::bus_addr_t addr_sr;
		bank_pkg::word_t data_sr;
		logic [31:0] rand_val;
		int count;
		begin
			count = txn_count[k];
			addr_sr = bus_pkg::bus_addr_t'(txn_addr[k]);
			data_sr = bank_pkg::word_t'(beat_bytes[txn_first[k]]);
			@(posedge clk);
			master_valid <= 1'b1;
			bank_sel     <= bank_pkg::bank_index_t'(txn_bank[k]);
			write_en     <= (txn_write[k] != 0);
			read_en      <= (txn_write[k] == 0);
			burst        <= {count[`SB_BURST_BITS-2:0], count != 0};
			rx_address   <= addr_sr[0];
			rx_data      <= data_sr[0]; // Reads ignore the data line.
			wait_handshake();
			master_valid <= 1'b0;
			for (int b = 1; b < `SB_ADDR_BITS; b++)
			begin
				addr_sr = addr_sr >> 1;
				data_sr = data_sr >> 1;
				rx_address <= addr_sr[0];
				rx_data    <= data_sr[0];
				@(posedge clk);
			end
			for (int beat = 1; beat <= count; beat++)
			begin
				// Steer bank_sel at another bank mid-burst.
				rand_val = next_rand();
				bank_sel <= bank_pkg::bank_index_t'(txn_bank[k] + 1
					+ int'(rand_val[9:8]) % 3);
				data_sr = bank_pkg::word_t'(beat_bytes[txn_first[k] + beat]);
				master_valid <= 1'b1;
				rx_data      <= data_sr[0];
				wait_handshake();
				master_valid <= 1'b0;
				for (int b = 1; b < `SB_DATA_BITS; b++)
				begin
					data_sr = data_sr >> 1;
					rx_data <= data_sr[0];
					@(posedge clk);
				end
			end
			read_en  <= 1'b0;
			write_en <= 1'b0;
			rand_val = next_rand();
			repeat (1 + int'(rand_val[17:16])) @(posedge clk); // Idle gap.
		end
	endtask

	task automatic check_frames();
		int n;
		begin
			while (rx_frames.size() < exp_frames.size())
				@(negedge clk);
			repeat (2 * `SB_DATA_BITS) @(negedge clk); // Room for stray frames.
			check_value("frame count", exp_frames.size(), rx_frames.size());
			n = rx_frames.size();
			if (exp_frames.size() < n)
				n = exp_frames.size();
			for (int i = 0; i < n; i++)
				check_value($sformatf("read byte %0d", i), exp_frames[i], rx_frames[i]);
		end
	endtask

	// Rebuilds tx frames LSB first.
	always @(negedge clk)
	begin
		if (reset)
		begin
			frame_bits = 0;
			if (tx_valid)
			begin
				$display("tx_valid is high during reset.");
				errors = errors + 1;
			end
		end
		else if (tx_valid)
		begin
			frame = {tx_data, frame[`SB_DATA_BITS-1:1]};
			frame_bits = frame_bits + 1;
			if (frame_bits == `SB_DATA_BITS)
			begin
				rx_frames.push_back(int'(frame));
				frame_bits = 0;
			end
		end
		else if (frame_bits != 0)
		begin
			$display("%0s: tx_valid dropped after %0d bits of a frame.", current_test,
				frame_bits);
			errors = errors + 1;
			test_errors = test_errors + 1;
			frame_bits = 0;
		end
	end

	always @(posedge clk)
	begin
		cycle_count = cycle_count + 1;
		if ((cycle_limit > 0) && (cycle_count >= cycle_limit))
		begin
			$display("Timeout: the DUT stopped responding after %0d cycles.", cycle_count);
			$display("Something failed");
			$finish;
		end
	end

	initial
	begin
		logic ok;
		int k;
		int beats;
		clk = 1'b0;
		reset = 1'b1;
		master_valid = 1'b0;
		bank_sel = '0;
		read_en = 1'b0;
		write_en = 1'b0;
		burst = '0;
		rx_address = 1'b0;
		rx_data = 1'b0;
		errors = 0;
		checks = 0;
		test_errors = 0;
		cycle_count = 0;
		cycle_limit = 0;
		frame_bits = 0;
		frame = '0;
		lcg_state = 32'hdeab;
		current_test = "reset";
		load_tests(ok);
		beats = 0;
		for (int i = 0; i < txn_count.size(); i++)
			beats = beats + txn_count[i] + 1;
		cycle_limit = 40 * beats + 200;
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_value("slave_ready", 1, int'(slave_ready));
		check_value("tx_valid", 0, int'(tx_valid));
		if (!ok)
			errors = errors + 1;
		else
		begin
			k = 0;
			for (int t = 0; t < test_names.size(); t++)
			begin
				current_test = $sformatf("%0s", test_names[t]);
				test_errors = 0;
				exp_frames.delete();
				rx_frames.delete();
				while ((k < txn_test.size()) && (txn_test[k] == t))
				begin
					drive_txn(k);
					if (txn_write[k] == 0)
					begin
						for (int b = 0; b <= txn_count[k]; b++)
							exp_frames.push_back(beat_bytes[txn_first[k] + b]);
					end
					k = k + 1;
				end
				check_frames();
				if (test_errors == 0)
					$display("test %0s: ok", current_test);
				else
					$display("test %0s: %0d errors", current_test, test_errors);
			end
		end
		$display("tests %0d, checks %0d, errors %0d", test_names.size(), checks, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule
